// File: hdl/alu_core_pkg.sv
/* alu core package
   widths and types shared by the ALU pipelines, the writeback arbiter and the top */

`default_nettype none

package alu_core_pkg;

    // ------------------------------------------------------------------------
    // widths

    localparam int WORD_W          = 32;
    localparam int SHAMT_W         = 5;
    localparam int PR_COUNT        = 128;
    localparam int ROB_ENTRIES     = 64;
    localparam int MAX_BANK_COUNT  = 8;
    // two PRF read ports per bank
    localparam int READ_PORT_COUNT = 2;

    // ------------------------------------------------------------------------
    // types

    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [$clog2(PR_COUNT)-1:0]        pr_t;
    typedef logic [$clog2(ROB_ENTRIES)-1:0]     rob_t;
    typedef logic [$clog2(MAX_BANK_COUNT)-1:0]  bank_t;

    // RV32 alu ops, funct7[5] in the msb and funct3 below
    // unlisted codes act like ALU_PASSB
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SLL   = 4'b0001,
        ALU_SLT   = 4'b0010,
        ALU_SLTU  = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_SRL   = 4'b0101,
        ALU_OR    = 4'b0110,
        ALU_AND   = 4'b0111,
        ALU_SUB   = 4'b1000,
        ALU_SRA   = 4'b1101,
        ALU_PASSB = 4'b1111
    } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/alu_wb_if.sv
/* alu writeback interface
   one result stream from a pipeline into the writeback arbiter */

`timescale 1ns/10ps
`default_nettype none

interface alu_wb_if import alu_core_pkg::*; ();

    logic  valid;
    word_t data;
    pr_t   pr;
    rob_t  rob;
    logic  ready;

    // pipeline side, fields held stable while valid and not ready
    modport source (
        output valid,
        output data,
        output pr,
        output rob,
        input  ready
    );

    // arbiter side
    modport sink (
        input  valid,
        input  data,
        input  pr,
        input  rob,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/alu_pipeline.sv
/* alu pipeline
   three stage integer ALU: operand collect, execute, writeback register */

`timescale 1ns/10ps
`default_nettype none

module alu_pipeline import alu_core_pkg::*; #(
    parameter int BANK_COUNT = 4
) (
    input  logic    CLK,
    input  logic    nRST,

    // issue from the ALU issue queue
    input  logic    issue_valid,
    input  alu_op_t issue_op,
    input  logic    issue_is_imm,
    input  word_t   issue_imm,
    input  logic    issue_a_unneeded,
    input  logic    issue_a_forward,
    input  bank_t   issue_a_bank,
    input  logic    issue_b_forward,
    input  bank_t   issue_b_bank,
    input  pr_t     issue_dest_pr,
    input  rob_t    issue_rob_index,
    output logic    issue_ready,

    // PRF read notifications and data
    input  logic    a_read_valid,
    input  logic    a_read_port,
    input  logic    b_read_valid,
    input  logic    b_read_port,
    input  word_t [BANK_COUNT-1:0][READ_PORT_COUNT-1:0] reg_read_data,
    input  word_t [BANK_COUNT-1:0]                      forward_data,

    alu_wb_if.source wb
);

    // bank bits actually needed to index this many banks
    localparam int BANK_SEL_W = (BANK_COUNT > 1) ? $clog2(BANK_COUNT) : 1;

    // ------------------------------------------------------------------------
    // stall chain

    logic wb_hold;
    logic ex_hold;

    // ------------------------------------------------------------------------
    // OC stage

    logic    valid_oc;
    alu_op_t op_oc;
    logic    is_imm_oc;
    word_t   imm_oc;
    logic    a_unneeded_oc;
    logic    a_saved_oc;
    logic    a_forward_oc;
    bank_t   a_bank_oc;
    logic    b_saved_oc;
    logic    b_forward_oc;
    bank_t   b_bank_oc;
    pr_t     dest_pr_oc;
    rob_t    rob_oc;
    word_t   a_saved_data;
    word_t   b_saved_data;
    word_t   a_oc;
    word_t   b_oc;
    logic    a_present;
    logic    b_present;
    logic    launch_oc;

    // ------------------------------------------------------------------------
    // EX stage

    logic    valid_ex;
    alu_op_t op_ex;
    word_t   a_ex;
    word_t   b_ex;
    pr_t     dest_pr_ex;
    rob_t    rob_ex;
    word_t   result_ex;

    // WB only stalls when it holds something the arbiter won't take
    assign wb_hold = wb.valid & ~wb.ready;
    assign ex_hold = valid_ex & wb_hold;

    // ------------------------------------------------------------------------
    // operand collect

    assign a_present = a_unneeded_oc | a_saved_oc | a_forward_oc | a_read_valid;
    assign b_present = is_imm_oc | b_saved_oc | b_forward_oc | b_read_valid;
    assign launch_oc = ~ex_hold & a_present & b_present;

    assign issue_ready = ~valid_oc | launch_oc;

    always_comb begin
        if (a_saved_oc) begin
            a_oc = a_saved_data;
        end else if (a_forward_oc) begin
            a_oc = forward_data[a_bank_oc[BANK_SEL_W-1:0]];
        end else begin
            a_oc = reg_read_data[a_bank_oc[BANK_SEL_W-1:0]][a_read_port];
        end

        if (b_saved_oc) begin
            b_oc = b_saved_data;
        end else if (is_imm_oc) begin
            b_oc = imm_oc;
        end else if (b_forward_oc) begin
            b_oc = forward_data[b_bank_oc[BANK_SEL_W-1:0]];
        end else begin
            b_oc = reg_read_data[b_bank_oc[BANK_SEL_W-1:0]][b_read_port];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc     <= 1'b0;
            a_saved_oc   <= 1'b0;
            a_forward_oc <= 1'b0;
            b_saved_oc   <= 1'b0;
            b_forward_oc <= 1'b0;
        end else if (!issue_ready) begin
            // waiting op, latch whatever arrived this cycle
            a_saved_oc   <= a_saved_oc | a_forward_oc | a_read_valid;
            a_forward_oc <= 1'b0;
            b_saved_oc   <= b_saved_oc | b_forward_oc | b_read_valid;
            b_forward_oc <= 1'b0;
        end else begin
            valid_oc     <= issue_valid;
            a_saved_oc   <= 1'b0;
            a_forward_oc <= issue_a_forward;
            b_saved_oc   <= 1'b0;
            b_forward_oc <= issue_b_forward;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc         <= issue_op;
            is_imm_oc     <= issue_is_imm;
            imm_oc        <= issue_imm;
            a_unneeded_oc <= issue_a_unneeded;
            a_bank_oc     <= issue_a_bank;
            b_bank_oc     <= issue_b_bank;
            dest_pr_oc    <= issue_dest_pr;
            rob_oc        <= issue_rob_index;
        end
        // saved copy follows the collect mux, frozen once the flag is set
        a_saved_data <= a_oc;
        b_saved_data <= b_oc;
    end

    // ------------------------------------------------------------------------
    // execute

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_ex <= 1'b0;
        end else if (!ex_hold) begin
            valid_ex <= valid_oc & launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_hold) begin
            op_ex      <= op_oc;
            a_ex       <= a_oc;
            b_ex       <= b_oc;
            dest_pr_ex <= dest_pr_oc;
            rob_ex     <= rob_oc;
        end
    end

    always_comb begin
        case (op_ex)
            ALU_ADD:  result_ex = a_ex + b_ex;
            ALU_SLL:  result_ex = a_ex << b_ex[SHAMT_W-1:0];
            ALU_SLT:  result_ex = {{(WORD_W-1){1'b0}}, $signed(a_ex) < $signed(b_ex)};
            ALU_SLTU: result_ex = {{(WORD_W-1){1'b0}}, a_ex < b_ex};
            ALU_XOR:  result_ex = a_ex ^ b_ex;
            ALU_SRL:  result_ex = a_ex >> b_ex[SHAMT_W-1:0];
            ALU_OR:   result_ex = a_ex | b_ex;
            ALU_AND:  result_ex = a_ex & b_ex;
            ALU_SUB:  result_ex = a_ex - b_ex;
            ALU_SRA:  result_ex = word_t'($signed(a_ex) >>> b_ex[SHAMT_W-1:0]);
            ALU_PASSB: result_ex = b_ex;
            default:  result_ex = b_ex;
        endcase
    end

    // ------------------------------------------------------------------------
    // writeback register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb.valid <= 1'b0;
        end else if (!wb_hold) begin
            wb.valid <= valid_ex;
        end
    end

    always_ff @(posedge CLK) begin
        if (!wb_hold) begin
            wb.data <= result_ex;
            wb.pr   <= dest_pr_ex;
            wb.rob  <= rob_ex;
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_arbiter.sv
/* writeback arbiter
   round-robin merge of two pipeline results onto the single PRF write port */

`timescale 1ns/10ps
`default_nettype none

module wb_arbiter import alu_core_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,

    alu_wb_if.sink pipe0,
    alu_wb_if.sink pipe1,

    // PRF write port
    output logic  wb_valid,
    output word_t wb_data,
    output pr_t   wb_pr,
    output rob_t  wb_rob_index,
    input  logic  wb_ready
);

    // 1 when pipe1 took the last transfer
    logic last_winner;
    logic grant1;

    // ------------------------------------------------------------------------
    // grant select

    // pipe1 wins alone, or on a tie when pipe0 won last
    assign grant1 = pipe1.valid & (~pipe0.valid | ~last_winner);

    assign wb_valid     = pipe0.valid | pipe1.valid;
    assign wb_data      = grant1 ? pipe1.data : pipe0.data;
    assign wb_pr        = grant1 ? pipe1.pr   : pipe0.pr;
    assign wb_rob_index = grant1 ? pipe1.rob  : pipe0.rob;

    // loser sees not ready and holds its WB register
    assign pipe0.ready = wb_ready & ~grant1;
    assign pipe1.ready = wb_ready & grant1;

    // ------------------------------------------------------------------------
    // priority pointer

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // pipe0 first out of reset
            last_winner <= 1'b1;
        end else if (wb_valid && wb_ready) begin
            last_winner <= grant1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dual_alu_top.sv
/* dual alu execute cluster
   two ALU pipelines sharing one register file write port through an arbiter */

`timescale 1ns/10ps
`default_nettype none

module dual_alu_top import alu_core_pkg::*; #(
    parameter int BANK_COUNT = 4
) (
    input  logic    CLK,
    input  logic    nRST,

    // pipeline 0 issue
    input  logic    issue0_valid,
    input  alu_op_t issue0_op,
    input  logic    issue0_is_imm,
    input  word_t   issue0_imm,
    input  logic    issue0_a_unneeded,
    input  logic    issue0_a_forward,
    input  bank_t   issue0_a_bank,
    input  logic    issue0_b_forward,
    input  bank_t   issue0_b_bank,
    input  pr_t     issue0_dest_pr,
    input  rob_t    issue0_rob_index,
    output logic    issue0_ready,

    // pipeline 1 issue
    input  logic    issue1_valid,
    input  alu_op_t issue1_op,
    input  logic    issue1_is_imm,
    input  word_t   issue1_imm,
    input  logic    issue1_a_unneeded,
    input  logic    issue1_a_forward,
    input  bank_t   issue1_a_bank,
    input  logic    issue1_b_forward,
    input  bank_t   issue1_b_bank,
    input  pr_t     issue1_dest_pr,
    input  rob_t    issue1_rob_index,
    output logic    issue1_ready,

    // register read notifications
    input  logic    a0_read_valid,
    input  logic    a0_read_port,
    input  logic    b0_read_valid,
    input  logic    b0_read_port,
    input  logic    a1_read_valid,
    input  logic    a1_read_port,
    input  logic    b1_read_valid,
    input  logic    b1_read_port,

    // PRF read and forward data
    input  word_t [BANK_COUNT-1:0][READ_PORT_COUNT-1:0] reg_read_data,
    input  word_t [BANK_COUNT-1:0]                      forward_data,

    // shared writeback port
    output logic    wb_valid,
    output word_t   wb_data,
    output pr_t     wb_pr,
    output rob_t    wb_rob_index,
    input  logic    wb_ready
);

    alu_wb_if wb_if_0 ();
    alu_wb_if wb_if_1 ();

    // ------------------------------------------------------------------------
    // pipelines

    alu_pipeline #(
        .BANK_COUNT (BANK_COUNT)
    ) i_alu_pipeline_0 (
        .CLK              (CLK),
        .nRST             (nRST),
        .issue_valid      (issue0_valid),
        .issue_op         (issue0_op),
        .issue_is_imm     (issue0_is_imm),
        .issue_imm        (issue0_imm),
        .issue_a_unneeded (issue0_a_unneeded),
        .issue_a_forward  (issue0_a_forward),
        .issue_a_bank     (issue0_a_bank),
        .issue_b_forward  (issue0_b_forward),
        .issue_b_bank     (issue0_b_bank),
        .issue_dest_pr    (issue0_dest_pr),
        .issue_rob_index  (issue0_rob_index),
        .issue_ready      (issue0_ready),
        .a_read_valid     (a0_read_valid),
        .a_read_port      (a0_read_port),
        .b_read_valid     (b0_read_valid),
        .b_read_port      (b0_read_port),
        .reg_read_data    (reg_read_data),
        .forward_data     (forward_data),
        .wb               (wb_if_0.source)
    );

    alu_pipeline #(
        .BANK_COUNT (BANK_COUNT)
    ) i_alu_pipeline_1 (
        .CLK              (CLK),
        .nRST             (nRST),
        .issue_valid      (issue1_valid),
        .issue_op         (issue1_op),
        .issue_is_imm     (issue1_is_imm),
        .issue_imm        (issue1_imm),
        .issue_a_unneeded (issue1_a_unneeded),
        .issue_a_forward  (issue1_a_forward),
        .issue_a_bank     (issue1_a_bank),
        .issue_b_forward  (issue1_b_forward),
        .issue_b_bank     (issue1_b_bank),
        .issue_dest_pr    (issue1_dest_pr),
        .issue_rob_index  (issue1_rob_index),
        .issue_ready      (issue1_ready),
        .a_read_valid     (a1_read_valid),
        .a_read_port      (a1_read_port),
        .b_read_valid     (b1_read_valid),
        .b_read_port      (b1_read_port),
        .reg_read_data    (reg_read_data),
        .forward_data     (forward_data),
        .wb               (wb_if_1.source)
    );

    // ------------------------------------------------------------------------
    // writeback merge

    wb_arbiter i_wb_arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .pipe0        (wb_if_0.sink),
        .pipe1        (wb_if_1.sink),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data),
        .wb_pr        (wb_pr),
        .wb_rob_index (wb_rob_index),
        .wb_ready     (wb_ready)
    );

endmodule

`default_nettype wire

// File: bench/dual_alu_chk.sv
/* dual alu checker
   handshake, arbitration and reset properties bound into the top level */

`timescale 1ns/10ps
`default_nettype none

module dual_alu_chk import alu_core_pkg::*; #(
    parameter int FIELD_W = $bits(word_t) + $bits(pr_t) + $bits(rob_t)
) (
    input logic               CLK,
    input logic               nRST,
    input logic               wb_valid,
    input logic               wb_ready,
    input logic               p0_valid,
    input logic               p0_ready,
    input logic [FIELD_W-1:0] p0_fields,
    input logic               p1_valid,
    input logic               p1_ready,
    input logic [FIELD_W-1:0] p1_fields,
    input logic               grant1
);

    // a stalled result keeps every field
    p0_hold: assert property (@(posedge CLK) disable iff (!nRST)
        p0_valid && !p0_ready |=> p0_valid && $stable(p0_fields))
        else $error("pipeline 0 result changed while stalled");

    p1_hold: assert property (@(posedge CLK) disable iff (!nRST)
        p1_valid && !p1_ready |=> p1_valid && $stable(p1_fields))
        else $error("pipeline 1 result changed while stalled");

    reset_quiet: assert property (@(posedge CLK)
        $rose(nRST) |=> !wb_valid && !p0_valid && !p1_valid)
        else $error("valid output high right after reset release");

    // contested port, winner flips after each transfer
    alternate: assert property (@(posedge CLK) disable iff (!nRST)
        p0_valid && p1_valid && wb_ready |=> !(p0_valid && p1_valid) || (grant1 != $past(grant1)))
        else $error("grant did not alternate between busy pipelines");

endmodule

bind dual_alu_top dual_alu_chk i_dual_alu_chk (
    .CLK       (CLK),
    .nRST      (nRST),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .p0_valid  (wb_if_0.valid),
    .p0_ready  (wb_if_0.ready),
    .p0_fields ({wb_if_0.data, wb_if_0.pr, wb_if_0.rob}),
    .p1_valid  (wb_if_1.valid),
    .p1_ready  (wb_if_1.ready),
    .p1_fields ({wb_if_1.data, wb_if_1.pr, wb_if_1.rob}),
    .grant1    (i_wb_arbiter.grant1)
);

`default_nettype wire

// File: bench/dual_alu_tb.sv
/* dual alu testbench
   random issue traffic on both pipelines, checked against a model of OC, ALU and arbiter */

`timescale 1ns/10ps
`default_nettype none

module dual_alu_tb import alu_core_pkg::*; ();

    localparam int BANKS          = 4;
    localparam int OPS_PER_RUN    = 300;
    localparam int PHASES         = 3;
    localparam int TIMEOUT_CYCLES = 20 * PHASES * 2 * OPS_PER_RUN;

    logic  CLK;
    logic  nRST;
    logic  iss_valid [2];
    logic  iss_is_imm [2];
    logic  iss_a_unneeded [2];
    logic  iss_a_fwd [2];
    logic  iss_b_fwd [2];
    logic  iss_ready [2];
    logic  a_rv [2];
    logic  a_port [2];
    logic  b_rv [2];
    logic  b_port [2];
    alu_op_t iss_op [2];
    word_t iss_imm [2];
    bank_t iss_a_bank [2];
    bank_t iss_b_bank [2];
    pr_t   iss_pr [2];
    rob_t  iss_rob [2];
    word_t [BANKS-1:0][READ_PORT_COUNT-1:0] reg_read_data;
    word_t [BANKS-1:0]                      forward_data;
    logic  wb_valid;
    word_t wb_data;
    pr_t   wb_pr;
    rob_t  wb_rob_index;
    logic  wb_ready;

    // OC mirror with one op per pipeline
    logic  oc_busy [2];
    logic  oc_first [2];
    logic  oc_unneeded [2];
    logic  oc_imm [2];
    logic  oc_afwd [2];
    logic  oc_bfwd [2];
    logic  a_have [2];
    logic  b_have [2];
    logic  [3:0] oc_op [2];
    bank_t oc_abank [2];
    bank_t oc_bbank [2];
    word_t oc_immv [2];
    word_t a_val [2];
    word_t b_val [2];
    pr_t   oc_pr [2];
    rob_t  oc_rob [2];

    // expected results by ROB index and issue order per pipeline
    word_t exp_data [64];
    pr_t   exp_pr [64];
    logic  pending [64];
    rob_t  order_q [2][$];
    int    rob_seq [2];
    int    issued [2];
    int    total_issued;
    int    retired;
    int    cycle_count;
    logic  last_pipe;
    string test_name;

    dual_alu_top #(
        .BANK_COUNT (BANKS)
    ) i_dual_alu_top (
        .issue0_valid      (iss_valid[0]),
        .issue0_op         (iss_op[0]),
        .issue0_is_imm     (iss_is_imm[0]),
        .issue0_imm        (iss_imm[0]),
        .issue0_a_unneeded (iss_a_unneeded[0]),
        .issue0_a_forward  (iss_a_fwd[0]),
        .issue0_a_bank     (iss_a_bank[0]),
        .issue0_b_forward  (iss_b_fwd[0]),
        .issue0_b_bank     (iss_b_bank[0]),
        .issue0_dest_pr    (iss_pr[0]),
        .issue0_rob_index  (iss_rob[0]),
        .issue0_ready      (iss_ready[0]),
        .issue1_valid      (iss_valid[1]),
        .issue1_op         (iss_op[1]),
        .issue1_is_imm     (iss_is_imm[1]),
        .issue1_imm        (iss_imm[1]),
        .issue1_a_unneeded (iss_a_unneeded[1]),
        .issue1_a_forward  (iss_a_fwd[1]),
        .issue1_a_bank     (iss_a_bank[1]),
        .issue1_b_forward  (iss_b_fwd[1]),
        .issue1_b_bank     (iss_b_bank[1]),
        .issue1_dest_pr    (iss_pr[1]),
        .issue1_rob_index  (iss_rob[1]),
        .issue1_ready      (iss_ready[1]),
        .a0_read_valid     (a_rv[0]),
        .a0_read_port      (a_port[0]),
        .b0_read_valid     (b_rv[0]),
        .b0_read_port      (b_port[0]),
        .a1_read_valid     (a_rv[1]),
        .a1_read_port      (a_port[1]),
        .b1_read_valid     (b_rv[1]),
        .b1_read_port      (b_port[1]),
        .*
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input word_t exp, input word_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: data expected %h, actual %h", test_name, exp, act));
    endtask

    task automatic check_pr(input pr_t exp, input pr_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: pr expected %h, actual %h", test_name, exp, act));
    endtask

    task automatic check_rob(input rob_t exp, input rob_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: rob expected %h, actual %h", test_name, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: %s expected %b, actual %b",
                                test_name, what, exp, act));
    endtask

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic word_t rand_word();
        word_t r;
        r = $urandom;
        // small magnitudes of either sign now and then
        if (chance(20))
            r = {{27{r[31]}}, r[4:0]};
        return r;
    endfunction

    // RV32 integer rules where undefined codes pass B
    function automatic word_t alu_model(input logic [3:0] code, input word_t a, input word_t b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a};
        case (code)
            4'h0:    return a + b;
            4'h1:    return a << sh;
            4'h2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            4'h3:    return {31'b0, a < b};
            4'h4:    return a ^ b;
            4'h5:    return a >> sh;
            4'h6:    return a | b;
            4'h7:    return a & b;
            4'h8:    return a - b;
            4'hd:    return word_t'(ext >> sh);
            default: return b;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // stimulus and model

    task automatic drive_inputs(input logic stream, input int ready_pct, input int read_pct);
        for (int k = 0; k < 2; k++) begin
            iss_valid[k]      = (issued[k] < OPS_PER_RUN) && (stream || chance(60));
            iss_a_unneeded[k] = chance(10);
            // an op without A only makes sense as a pass of B
            if (iss_a_unneeded[k])
                iss_op[k] = alu_op_t'(chance(50) ? 4'hf : 4'ha);
            else
                iss_op[k] = alu_op_t'(4'($urandom));
            iss_is_imm[k] = chance(25);
            iss_imm[k]    = rand_word();
            iss_a_fwd[k]  = stream || chance(30);
            iss_b_fwd[k]  = stream || chance(30);
            iss_a_bank[k] = bank_t'($urandom_range(0, BANKS - 1));
            iss_b_bank[k] = bank_t'($urandom_range(0, BANKS - 1));
            iss_pr[k]     = pr_t'($urandom);
            iss_rob[k]    = rob_t'({rob_seq[k][4:0], 1'(k)});
            a_rv[k] = oc_busy[k] && !(oc_unneeded[k] || a_have[k] || (oc_first[k] && oc_afwd[k]))
                      && chance(read_pct);
            b_rv[k] = oc_busy[k] && !(oc_imm[k] || b_have[k] || (oc_first[k] && oc_bfwd[k]))
                      && chance(read_pct);
            a_port[k] = chance(50);
            b_port[k] = chance(50);
        end
        for (int i = 0; i < BANKS; i++) begin
            forward_data[i] = rand_word();
            for (int p = 0; p < READ_PORT_COUNT; p++)
                reg_read_data[i][p] = rand_word();
        end
        wb_ready = stream || chance(ready_pct);
    endtask

    task automatic sample_outputs();
        logic ap;
        logic bp;
        logic pipe;
        rob_t r;
        rob_t front;
        if (wb_valid && wb_ready) begin
            r    = wb_rob_index;
            pipe = r[0];
            if (!pending[r])
                abort_run($sformatf("rob %0d written back while not in flight", r));
            if (i_dual_alu_top.wb_if_0.valid && i_dual_alu_top.wb_if_1.valid)
                check_flag("granted pipeline", !last_pipe, pipe);
            front = order_q[pipe].pop_front();
            check_rob(front, r);
            check_pr(exp_pr[r], wb_pr);
            check_data(exp_data[r], wb_data);
            pending[r] = 1'b0;
            last_pipe  = pipe;
            retired++;
        end
        for (int k = 0; k < 2; k++) begin
            if (oc_busy[k]) begin
                ap = oc_unneeded[k] || a_have[k] || (oc_first[k] && oc_afwd[k]) || a_rv[k];
                bp = oc_imm[k] || b_have[k] || (oc_first[k] && oc_bfwd[k]) || b_rv[k];
                if (ap && !a_have[k] && !oc_unneeded[k]) begin
                    a_val[k]  = (oc_first[k] && oc_afwd[k]) ? forward_data[oc_abank[k]]
                                : reg_read_data[oc_abank[k]][a_port[k]];
                    a_have[k] = 1'b1;
                end
                if (bp && !b_have[k]) begin
                    if (oc_imm[k])
                        b_val[k] = oc_immv[k];
                    else if (oc_first[k] && oc_bfwd[k])
                        b_val[k] = forward_data[oc_bbank[k]];
                    else
                        b_val[k] = reg_read_data[oc_bbank[k]][b_port[k]];
                    b_have[k] = 1'b1;
                end
                if (!(ap && bp))
                    check_flag("issue ready with operand missing", 1'b0, iss_ready[k]);
                if (iss_ready[k]) begin
                    exp_data[oc_rob[k]] = alu_model(oc_op[k], a_val[k], b_val[k]);
                    exp_pr[oc_rob[k]]   = oc_pr[k];
                    oc_busy[k] = 1'b0;
                end
                oc_first[k] = 1'b0;
            end else begin
                check_flag("issue ready with empty OC", 1'b1, iss_ready[k]);
            end
            if (iss_valid[k] && iss_ready[k]) begin
                if (pending[iss_rob[k]])
                    abort_run("rob index reused while still in flight");
                oc_busy[k]     = 1'b1;
                oc_first[k]    = 1'b1;
                a_have[k]      = 1'b0;
                b_have[k]      = 1'b0;
                oc_op[k]       = iss_op[k];
                oc_unneeded[k] = iss_a_unneeded[k];
                oc_imm[k]      = iss_is_imm[k];
                oc_immv[k]     = iss_imm[k];
                oc_afwd[k]     = iss_a_fwd[k];
                oc_bfwd[k]     = iss_b_fwd[k];
                oc_abank[k]    = iss_a_bank[k];
                oc_bbank[k]    = iss_b_bank[k];
                oc_pr[k]       = iss_pr[k];
                oc_rob[k]      = iss_rob[k];
                pending[iss_rob[k]] = 1'b1;
                order_q[k].push_back(iss_rob[k]);
                rob_seq[k]++;
                issued[k]++;
                total_issued++;
            end
        end
    endtask

    task automatic run_phase(input string name, input logic stream,
                             input int ready_pct, input int read_pct);
        test_name = name;
        issued[0] = 0;
        issued[1] = 0;
        while (issued[0] < OPS_PER_RUN || issued[1] < OPS_PER_RUN || retired != total_issued) begin
            @(posedge CLK);
            #1;
            drive_inputs(stream, ready_pct, read_pct);
            @(negedge CLK);
            sample_outputs();
        end
    endtask

    // ------------------------------------------------------------------------
    // sequence

    initial begin
        void'($urandom(32'h50b2));
        nRST         = 1'b0;
        wb_ready     = 1'b0;
        total_issued = 0;
        retired      = 0;
        last_pipe    = 1'b1;
        for (int k = 0; k < 2; k++) begin
            iss_valid[k]      = 1'b0;
            iss_op[k]         = ALU_ADD;
            iss_is_imm[k]     = 1'b0;
            iss_imm[k]        = '0;
            iss_a_unneeded[k] = 1'b0;
            iss_a_fwd[k]      = 1'b0;
            iss_a_bank[k]     = '0;
            iss_b_fwd[k]      = 1'b0;
            iss_b_bank[k]     = '0;
            iss_pr[k]         = '0;
            iss_rob[k]        = '0;
            a_rv[k]           = 1'b0;
            a_port[k]         = 1'b0;
            b_rv[k]           = 1'b0;
            b_port[k]         = 1'b0;
            oc_busy[k]        = 1'b0;
            rob_seq[k]        = 0;
        end
        for (int i = 0; i < 64; i++)
            pending[i] = 1'b0;
        reg_read_data = '0;
        forward_data  = '0;

        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        test_name = "reset";
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("issue0_ready", 1'b1, iss_ready[0]);
        check_flag("issue1_ready", 1'b1, iss_ready[1]);

        run_phase("random_mix", 1'b0, 70, 50);
        run_phase("backpressure", 1'b0, 30, 30);
        // both pipelines saturated and the port always ready
        run_phase("stream", 1'b1, 100, 0);

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        abort_run("timeout: not every issued op was written back in time");
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/alu_core_pkg.sv
hdl/alu_wb_if.sv
hdl/alu_pipeline.sv
hdl/wb_arbiter.sv
hdl/dual_alu_top.sv
bench/dual_alu_chk.sv
bench/dual_alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the dual ALU testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dual_alu_tb -f tb.f --Mdir obj_dir -o dual_alu_sim

# a failing run still leaves its log for the search below
./obj_dir/dual_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
